// ==== include/tile_macros.svh ====
//==============================
// Tile macros
// One-hot struct selection for datapath muxing
//==============================
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

//==============================
// TILE_ONEHOT_MUX
//==============================
// Selects ARR[i] into OUT where SEL[i] is set; OUT is zero when SEL is zero
// Expands to procedural statements, so place it inside an always_comb block
// SEL is expected one-hot, more than one bit set ORs the entries together
`define TILE_ONEHOT_MUX(OUT, ARR, SEL) \
    OUT = '0; \
    for (int mux_i = 0; mux_i < $bits(SEL); mux_i++) begin \
        if (SEL[mux_i]) begin \
            OUT = OUT | ARR[mux_i]; \
        end \
    end

`endif

// ==== logic/tile_pkg.sv ====
//==============================
// Tile package
// Transaction, config, APB and register map types
//==============================
package tile_pkg;

    localparam int CARD_COUNT = 5; // Output cardinals of a tile

    //==============================
    // Transaction types
    //==============================
    // Destination port on the next tile
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_cardinal;

    typedef struct packed {
        t_cardinal   next_tile_fifo_arb_id; // Target cardinal downstream
        logic [3:0]  src_id;                // Originating client
        logic [31:0] payload;
    } t_tile_trans;

    // Config from the register block to the arbiter
    typedef struct packed {
        logic [3:0]            client_en; // One bit per client lane
        logic [CARD_COUNT-1:0] dest_en;   // Indexed by t_cardinal
    } t_arb_cfg;

    //==============================
    // APB
    //==============================
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } t_apb_req;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr; // Unmapped offset or write to read-only
    } t_apb_rsp;

    // Register offsets
    typedef enum logic [7:0] {
        REG_CLIENT_EN  = 8'h00, // RW
        REG_DEST_EN    = 8'h04, // RW
        REG_CNT_CLR    = 8'h08, // WO, clears all grant counters
        REG_GRANT_CNT0 = 8'h10, // RO
        REG_GRANT_CNT1 = 8'h14,
        REG_GRANT_CNT2 = 8'h18,
        REG_GRANT_CNT3 = 8'h1C
    } t_reg_addr;

endpackage

// ==== logic/trans_fifo.sv ====
//==============================
// Transaction FIFO
// Circular buffer with full/empty flags
//==============================
`timescale 1ns/1ps

module trans_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  tile_pkg::t_tile_trans push_data,
    input  logic                 pop,
    output tile_pkg::t_tile_trans pop_data,
    output logic                 full,
    output logic                 empty
);
    import tile_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    t_tile_trans      mem [FIFO_DEPTH]; // Storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;            // Occupancy
    logic             do_push;
    logic             do_pop;

    // Wrap at FIFO_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push && !full;  // Push while full is dropped
    assign do_pop  = pop && !empty;  // Pop while empty is dropped

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];   // Head always visible

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Idle or push+pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== logic/rr_arbiter.sv ====
//==============================
// Round-robin arbiter
// Combinational one-hot grant, rotating priority
//==============================
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int NUM_CLIENTS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [NUM_CLIENTS-1:0] valid_candidate,
    output logic [NUM_CLIENTS-1:0] grant            // One-hot or zero
);

    localparam int PTR_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

    logic [PTR_W-1:0] ptr;     // Highest-priority client this cycle
    logic [PTR_W-1:0] winner;
    logic             found;

    //==============================
    // Grant search
    //==============================
    // Scan from ptr upward with wrap, first candidate wins
    always_comb begin
        grant  = '0;
        winner = ptr;
        found  = 1'b0;
        for (int off = 0; off < NUM_CLIENTS; off++) begin
            int idx;
            idx = int'(ptr) + off;
            if (idx >= NUM_CLIENTS) begin
                idx = idx - NUM_CLIENTS; // Wrap around
            end
            if (!found && valid_candidate[idx]) begin
                grant[idx] = 1'b1;
                winner     = PTR_W'(idx);
                found      = 1'b1;
            end
        end
    end

    //==============================
    // Priority pointer
    //==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (found) begin
            // Client after the winner gets top priority next
            if (winner == PTR_W'(NUM_CLIENTS - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= winner + 1'b1;
            end
        end
    end

endmodule

// ==== logic/fifo_arb.sv ====
//==============================
// FIFO arbiter
// Per-client buffering and ready-gated winner select
//==============================
`timescale 1ns/1ps
`include "tile_macros.svh"

module fifo_arb #(
    parameter int NUM_CLIENTS = 4,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic                                    clk,
    input  logic                                    rst,
    //==============================
    // From neighbor lanes
    //==============================
    input  logic                  [NUM_CLIENTS-1:0] alloc_valid,
    input  tile_pkg::t_tile_trans [NUM_CLIENTS-1:0] alloc_req,
    output logic                  [NUM_CLIENTS-1:0] alloc_ready, // FIFO not full
    //==============================
    // Toward the next tile
    //==============================
    input  logic         [tile_pkg::CARD_COUNT-1:0] dest_ready,  // Indexed by cardinal
    input  tile_pkg::t_arb_cfg                      cfg,
    output tile_pkg::t_tile_trans                   winner_req,
    output logic                                    winner_valid,
    output logic                  [NUM_CLIENTS-1:0] grant        // To grant counters
);
    import tile_pkg::*;

    t_tile_trans [NUM_CLIENTS-1:0] head;            // FIFO head per client
    logic        [NUM_CLIENTS-1:0] push;
    logic        [NUM_CLIENTS-1:0] pop;
    logic        [NUM_CLIENTS-1:0] full;
    logic        [NUM_CLIENTS-1:0] empty;
    logic        [NUM_CLIENTS-1:0] valid_candidate;

    assign alloc_ready = ~full;
    assign push        = alloc_valid & alloc_ready; // Valid without ready is dropped

    //==============================
    // Client FIFOs
    //==============================
    for (genvar i = 0; i < NUM_CLIENTS; i++) begin : gen_fifo
        trans_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) fifo_inst (
            .clk       (clk),
            .rst       (rst),
            .push      (push[i]),
            .push_data (alloc_req[i]),
            .pop       (pop[i]),      // Winner leaves at this edge
            .pop_data  (head[i]),
            .full      (full[i]),
            .empty     (empty[i])
        );
    end

    // Candidate needs data, an enabled lane, and an enabled ready destination
    always_comb begin
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            t_cardinal card;
            card = head[i].next_tile_fifo_arb_id;
            valid_candidate[i] = !empty[i]
                              && cfg.client_en[i]
                              && cfg.dest_en[card]
                              && dest_ready[card];
        end
    end

    //==============================
    // Arbitration and output
    //==============================
    rr_arbiter #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) arb_inst (
        .clk             (clk),
        .rst             (rst),
        .valid_candidate (valid_candidate),
        .grant           (grant)
    );

    assign pop          = grant;  // Downstream already holds ready, so deliver now
    assign winner_valid = |grant;

    // Route the granted head to the output
    always_comb begin
        `TILE_ONEHOT_MUX(winner_req, head, grant)
    end

endmodule

// ==== logic/arb_cfg_regs.sv ====
//==============================
// Arbiter config registers
// APB lane/destination enables and grant counters
//==============================
`timescale 1ns/1ps

module arb_cfg_regs #(
    parameter int NUM_CLIENTS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  tile_pkg::t_apb_req     apb_req,
    output tile_pkg::t_apb_rsp     apb_rsp,
    input  logic [NUM_CLIENTS-1:0] grant,   // One-hot winner from the arbiter
    output tile_pkg::t_arb_cfg     cfg
);
    import tile_pkg::*;

    localparam logic [3:0]            CLIENT_EN_RST = 4'hF;
    localparam logic [CARD_COUNT-1:0] DEST_EN_RST   = 5'h1F;

    logic        access;      // APB access phase
    logic        wr_en;
    logic        cnt_clr;
    logic        mapped;
    logic        read_only;
    logic [1:0]  cnt_sel;     // Counter index from offset
    logic [31:0] rdata;
    logic [15:0] grant_cnt [NUM_CLIENTS];

    assign access  = apb_req.psel && apb_req.penable;
    assign wr_en   = access && apb_req.pwrite;
    assign cnt_clr = wr_en && (apb_req.paddr == REG_CNT_CLR);
    assign cnt_sel = apb_req.paddr[3:2];

    //==============================
    // Address decode and read mux
    //==============================
    always_comb begin
        rdata     = '0;
        mapped    = 1'b1;
        read_only = 1'b0;
        case (apb_req.paddr)
            REG_CLIENT_EN: rdata = 32'(cfg.client_en);
            REG_DEST_EN:   rdata = 32'(cfg.dest_en);
            REG_CNT_CLR:   rdata = '0;              // Write-only, reads as zero
            REG_GRANT_CNT0, REG_GRANT_CNT1, REG_GRANT_CNT2, REG_GRANT_CNT3: begin
                read_only = 1'b1;
                rdata     = {16'h0, grant_cnt[cnt_sel]};
            end
            default:       mapped = 1'b0;
        endcase
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;  // Zero wait states
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));

    //==============================
    // Control registers
    //==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.client_en <= CLIENT_EN_RST;
            cfg.dest_en   <= DEST_EN_RST;
        end else if (wr_en) begin
            case (apb_req.paddr)
                REG_CLIENT_EN: cfg.client_en <= apb_req.pwdata[3:0];
                REG_DEST_EN:   cfg.dest_en   <= apb_req.pwdata[CARD_COUNT-1:0];
                default:       ;              // Other offsets hold no config
            endcase
        end
    end

    // Clear strobe wins over a same-cycle grant
    always_ff @(posedge clk) begin
        if (rst || cnt_clr) begin
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                grant_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                if (grant[i]) begin
                    grant_cnt[i] <= grant_cnt[i] + 16'd1; // Wraps at 2^16
                end
            end
        end
    end

endmodule

// ==== logic/tile_out_port.sv ====
//==============================
// Tile output port
// Config block plus buffered round-robin arbiter
//==============================
`timescale 1ns/1ps

module tile_out_port #(
    parameter int NUM_CLIENTS = 4,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic                                    clk,
    input  logic                                    rst,
    // Configuration bus
    input  tile_pkg::t_apb_req                      apb_req,
    output tile_pkg::t_apb_rsp                      apb_rsp,
    // Client lanes
    input  logic                  [NUM_CLIENTS-1:0] alloc_valid,
    input  tile_pkg::t_tile_trans [NUM_CLIENTS-1:0] alloc_req,
    output logic                  [NUM_CLIENTS-1:0] alloc_ready,
    // Downstream
    input  logic         [tile_pkg::CARD_COUNT-1:0] dest_ready,
    output tile_pkg::t_tile_trans                   winner_req,
    output logic                                    winner_valid
);
    import tile_pkg::*;

    t_arb_cfg               cfg;   // Lane and destination enables
    logic [NUM_CLIENTS-1:0] grant; // Feeds the grant counters

    arb_cfg_regs #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) cfg_regs_inst (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .grant   (grant),
        .cfg     (cfg)
    );

    fifo_arb #(
        .NUM_CLIENTS (NUM_CLIENTS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) fifo_arb_inst (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .alloc_req    (alloc_req),
        .alloc_ready  (alloc_ready),
        .dest_ready   (dest_ready),
        .cfg          (cfg),
        .winner_req   (winner_req),
        .winner_valid (winner_valid),
        .grant        (grant)
    );

endmodule

// ==== tests/tile_out_port_assert.sv ====
//==============================
// FIFO arbiter assertions
// Grant, readiness and pop rules
//==============================
`timescale 1ns/1ps

module tile_out_port_assert #(
    parameter int NUM_CLIENTS = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [NUM_CLIENTS-1:0]          grant,
    input  logic [NUM_CLIENTS-1:0]          empty,
    input  logic [NUM_CLIENTS-1:0]          pop,
    input  logic                            winner_valid,
    input  tile_pkg::t_tile_trans           winner_req,
    input  logic [tile_pkg::CARD_COUNT-1:0] dest_ready
);
    import tile_pkg::*;

    int fail_count = 0; // Failed assertions so far

    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else begin
            $error("grant has more than one bit set");
            fail_count++;
        end

    // Delivery only toward a cardinal that holds ready
    dest_ready_held: assert property (@(posedge clk) disable iff (rst)
        winner_valid |-> dest_ready[winner_req.next_tile_fifo_arb_id])
        else begin
            $error("winner delivered to a cardinal that is not ready");
            fail_count++;
        end

    no_empty_grant: assert property (@(posedge clk) disable iff (rst) (grant & empty) == '0)
        else begin
            $error("grant given to an empty FIFO");
            fail_count++;
        end

    pop_with_winner: assert property (@(posedge clk) disable iff (rst) |pop |-> winner_valid)
        else begin
            $error("FIFO popped without winner_valid");
            fail_count++;
        end

endmodule

// ==== tests/tb_tile_out_port.sv ====
//==============================
// Output port testbench
// Random traffic against a queue model
//==============================
`timescale 1ns/1ps

module tb_tile_out_port;
    import tile_pkg::*;

    localparam int NUM_CLIENTS = 4;
    localparam int FIFO_DEPTH  = 4;

    logic                          clk;
    logic                          rst;
    t_apb_req                      apb_req;
    t_apb_rsp                      apb_rsp;
    logic        [NUM_CLIENTS-1:0] alloc_valid;
    t_tile_trans [NUM_CLIENTS-1:0] alloc_req;
    logic        [NUM_CLIENTS-1:0] alloc_ready;
    logic         [CARD_COUNT-1:0] dest_ready;
    t_tile_trans                   winner_req;
    logic                          winner_valid;

    //==============================
    // Stimulus controls and model
    //==============================
    string                 test_name;
    t_apb_req              nxt_apb;      // APB request for the next cycle
    logic                  traffic_on;
    logic                  dest_rand;    // Random dest_ready when set
    logic [CARD_COUNT-1:0] dest_fixed;
    t_tile_trans           q [NUM_CLIENTS][$]; // Expected FIFO contents
    logic [3:0]            m_client_en;
    logic [CARD_COUNT-1:0] m_dest_en;
    logic [15:0]           m_cnt [NUM_CLIENTS]; // Deliveries per client modulo 2^16
    int                    m_ptr;        // Round-robin priority

    tile_out_port #(
        .NUM_CLIENTS (NUM_CLIENTS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) tile_out_port_inst (
        .clk          (clk),
        .rst          (rst),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .alloc_valid  (alloc_valid),
        .alloc_req    (alloc_req),
        .alloc_ready  (alloc_ready),
        .dest_ready   (dest_ready),
        .winner_req   (winner_req),
        .winner_valid (winner_valid)
    );

    bind fifo_arb tile_out_port_assert #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) arb_assert_inst (
        .clk          (clk),
        .rst          (rst),
        .grant        (grant),
        .empty        (empty),
        .pop          (pop),
        .winner_valid (winner_valid),
        .winner_req   (winner_req),
        .dest_ready   (dest_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
            stop_run();
        end
    endtask

    function automatic int queued();
        int total;
        total = 0;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            total += q[i].size();
        end
        return total;
    endfunction

    // Expected winner from heads that were present before this cycle's edge
    task automatic model_cycle();
        logic [NUM_CLIENTS-1:0] cand;
        t_cardinal              card;
        int                     win;
        int                     idx;
        cand = '0;
        win  = -1;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            check_eq("alloc_ready", q[i].size() < FIFO_DEPTH, alloc_ready[i]);
            if (q[i].size() > 0) begin
                card    = q[i][0].next_tile_fifo_arb_id;
                cand[i] = m_client_en[i] && m_dest_en[card] && dest_ready[card];
            end
        end
        for (int off = 0; off < NUM_CLIENTS; off++) begin
            idx = (m_ptr + off) % NUM_CLIENTS;
            if (win < 0 && cand[idx]) begin
                win = idx;
            end
        end
        check_eq("winner_valid", win >= 0, winner_valid);
        if (win >= 0) begin
            check_eq("winner_req", q[win][0], winner_req);
            void'(q[win].pop_front());
            m_cnt[win] = m_cnt[win] + 16'd1;
            m_ptr      = (win + 1) % NUM_CLIENTS;
        end
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            if (alloc_valid[i] && alloc_ready[i]) begin
                q[i].push_back(alloc_req[i]); // Accepted at the coming edge
            end
        end
    endtask

    // Drive just after the edge, check at the falling edge
    task automatic run_cycle();
        @(posedge clk);
        #2;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            alloc_valid[i] = traffic_on && ($urandom % 2 == 1);
            alloc_req[i].next_tile_fifo_arb_id = t_cardinal'($urandom % CARD_COUNT);
            alloc_req[i].src_id                = 4'(i);
            alloc_req[i].payload               = $urandom;
        end
        dest_ready = dest_rand ? CARD_COUNT'($urandom) : dest_fixed;
        apb_req    = nxt_apb;
        @(negedge clk);
        model_cycle();
    endtask

    //==============================
    // APB tasks
    //==============================
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waits;
        waits   = 0;
        nxt_apb = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        run_cycle();                  // Setup phase
        nxt_apb.penable = 1'b1;
        run_cycle();                  // Access phase
        while (!apb_rsp.pready) begin
            waits++;
            if (waits > 20) begin
                $display("Timeout: APB slave never raised pready");
                stop_run();
            end
            run_cycle();
        end
        rdata   = apb_rsp.prdata;
        err     = apb_rsp.pslverr;
        nxt_apb = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, wdata, rdata, err);
        check_eq("pslverr on write", exp_err, err);
        if (!exp_err) begin
            case (addr)                  // Takes effect at the access edge
                REG_CLIENT_EN: m_client_en = wdata[3:0];
                REG_DEST_EN:   m_dest_en   = wdata[CARD_COUNT-1:0];
                REG_CNT_CLR:   m_cnt       = '{default: '0};
                default:       ;
            endcase
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check_eq("pslverr on read", exp_err, err);
        if (!exp_err) begin
            check_eq($sformatf("prdata at %02h", addr), exp, rdata);
        end
    endtask

    //==============================
    // Test sequence
    //==============================
    initial begin
        int wait_cycles;
        void'($urandom(78));
        rst         = 1'b1;
        alloc_valid = '0;
        alloc_req   = '0;
        dest_ready  = '0;
        apb_req     = '0;
        nxt_apb     = '0;
        traffic_on  = 1'b0;
        dest_rand   = 1'b0;
        dest_fixed  = '0;
        test_name   = "reset";
        m_client_en = 4'hF;  // Register reset values
        m_dest_en   = 5'h1F;
        m_cnt       = '{default: '0};
        m_ptr       = 0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        nxt_apb.paddr = 8'hFF;  // Idle bus parked on an unmapped offset
        repeat (3) run_cycle();
        check_eq("pslverr after reset", 0, apb_rsp.pslverr);
        apb_read(REG_CLIENT_EN, 32'hF, 1'b0);
        apb_read(REG_DEST_EN, 32'h1F, 1'b0);
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            apb_read(8'(REG_GRANT_CNT0) + 8'(4 * i), 32'h0, 1'b0);
        end

        test_name  = "fifo_order_rr";  // All destinations ready
        traffic_on = 1'b1;
        dest_fixed = '1;
        repeat (300) run_cycle();

        test_name = "dest_ready";
        dest_rand = 1'b1;
        repeat (300) run_cycle();

        test_name = "config";
        for (int n = 0; n < 20; n++) begin
            apb_write(REG_CLIENT_EN, $urandom, 1'b0);
            repeat (5) run_cycle();
            apb_write(REG_DEST_EN, $urandom, 1'b0);
            repeat (5) run_cycle();
        end
        apb_read(REG_DEST_EN, 32'(m_dest_en), 1'b0);
        apb_write(REG_GRANT_CNT1, 32'h1, 1'b1); // Read-only
        apb_write(8'h24, 32'h1, 1'b1);          // Unmapped
        apb_read(8'h0C, 32'h0, 1'b1);
        apb_write(REG_CLIENT_EN, 32'hF, 1'b0);
        apb_write(REG_DEST_EN, 32'h1F, 1'b0);

        test_name   = "counters";
        traffic_on  = 1'b0;
        dest_rand   = 1'b0;
        dest_fixed  = '1;
        wait_cycles = 0;
        while (queued() != 0) begin    // Drain every client
            wait_cycles++;
            if (wait_cycles > 200) begin
                $display("Timeout: client FIFOs did not drain");
                stop_run();
            end
            run_cycle();
        end
        dest_fixed = '0;               // Hold counters still while reading
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            apb_read(8'(REG_GRANT_CNT0) + 8'(4 * i), {16'h0, m_cnt[i]}, 1'b0);
        end
        apb_write(REG_CNT_CLR, 32'h0, 1'b0);
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            apb_read(8'(REG_GRANT_CNT0) + 8'(4 * i), 32'h0, 1'b0);
        end

        if (tile_out_port_inst.fifo_arb_inst.arb_assert_inst.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Bound assertions reported failures");
            stop_run();
        end
    end

endmodule

// ==== build.f ====
+incdir+include
logic/tile_pkg.sv
logic/trans_fifo.sv
logic/rr_arbiter.sv
logic/fifo_arb.sv
logic/arb_cfg_regs.sv
logic/tile_out_port.sv
tests/tile_out_port_assert.sv
tests/tb_tile_out_port.sv
